/* verilog/mmu_params.svh */
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// tlb geometry
`define MMU_TLB_ENTRY_NUM 16

// crmd fields
`define MMU_CRMD_PLV  1:0
`define MMU_CRMD_DA   3
`define MMU_CRMD_PG   4
`define MMU_CRMD_DATF 6:5
`define MMU_CRMD_DATM 8:7

// dmw0/dmw1 fields
`define MMU_DMW_PLV0 0
`define MMU_DMW_PLV3 3
`define MMU_DMW_MAT  5:4
`define MMU_DMW_PSEG 27:25
`define MMU_DMW_VSEG 31:29

// asid and tlbidx fields
`define MMU_ASID_ASID    9:0
`define MMU_TLBIDX_INDEX 3:0

// access kind codes
`define MMU_MEM_FETCH 2'd0
`define MMU_MEM_LOAD  2'd1
`define MMU_MEM_STORE 2'd2

`endif

/* verilog/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    // privilege levels a dmw can enable
    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER   = 2'd3;

    // loongarch exception codes raised by translation
    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_PIL  = 6'h01,
        ECODE_PIS  = 6'h02,
        ECODE_PIF  = 6'h03,
        ECODE_PME  = 6'h04,
        ECODE_PPI  = 6'h07,
        ECODE_TLBR = 6'h3f
    } ecode_t;

    // snapshot of the csrs the mmu looks at
    typedef struct packed {
        logic [31:0] crmd;
        logic [31:0] asid;
        logic [31:0] dmw0;
        logic [31:0] dmw1;
        logic [31:0] tlbidx;
    } csr_t;

endpackage

/* verilog/tlb_pkg.sv */
`include "mmu_params.svh"

package tlb_pkg;

    import csr_pkg::*;

    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [3:0]  tlb_index_t;
    typedef logic [`MMU_TLB_ENTRY_NUM-1:0] tlb_onehot_t;

    typedef struct packed {
        logic  e;
        logic  g;
        logic  huge_page;
        asid_t asid;
        vppn_t vppn;
    } tlb_key_t;

    typedef struct packed {
        logic v;
        logic d;
        mat_t mat;
        plv_t plv;
        ppn_t ppn;
    } tlb_value_t;

    // value[0] is the even page, value[1] the odd page
    typedef struct packed {
        tlb_key_t         key;
        tlb_value_t [1:0] value;
    } tlb_entry_t;

    typedef struct packed {
        tlb_onehot_t mask;
        tlb_entry_t  entry;
    } tlb_write_req_t;

    typedef enum logic [1:0] {
        MEM_FETCH = `MMU_MEM_FETCH,
        MEM_LOAD  = `MMU_MEM_LOAD,
        MEM_STORE = `MMU_MEM_STORE
    } mem_type_t;

    typedef enum logic [2:0] {
        INV_ALL0       = 3'd0,
        INV_ALL1       = 3'd1,
        INV_GLOBAL     = 3'd2,
        INV_NONGLOBAL  = 3'd3,
        INV_NG_ASID    = 3'd4,
        INV_NG_ASID_VA = 3'd5,
        INV_G_ASID_VA  = 3'd6
    } invtlb_op_t;

    typedef struct packed {
        paddr_t pa;
        mat_t   mat;
        logic   valid;
    } trans_result_t;

    // 4MB pages compare only the upper 10 bits of the vppn
    function automatic logic vppn_match(input vaddr_t va, input logic huge_page,
                                        input vppn_t vppn);
        if (huge_page) begin
            return va[31:22] == vppn[18:9];
        end
        return va[31:13] == vppn;
    endfunction

endpackage

/* verilog/tlb_array.sv */
`timescale 1ns/1ps
`include "mmu_params.svh"

module tlb_array import tlb_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  tlb_write_req_t                      wr_req_i,
    output tlb_entry_t [`MMU_TLB_ENTRY_NUM-1:0] entries_o
);

    tlb_onehot_t                         e_q;
    tlb_entry_t [`MMU_TLB_ENTRY_NUM-1:0] entry_q;

    // per-entry exist bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < `MMU_TLB_ENTRY_NUM; i++) begin
                if (wr_req_i.mask[i]) begin
                    e_q[i] <= wr_req_i.entry.key.e;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `MMU_TLB_ENTRY_NUM; i++) begin
            if (wr_req_i.mask[i]) begin
                entry_q[i] <= wr_req_i.entry;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `MMU_TLB_ENTRY_NUM; i++) begin
            entries_o[i]       = entry_q[i];
            entries_o[i].key.e = e_q[i];
        end
    end

    // only invalidation may clear several entries at once
    a_single_valid_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_req_i.entry.key.e |-> $onehot0(wr_req_i.mask));

endmodule

/* verilog/tlb_write_arbiter.sv */
`timescale 1ns/1ps

module tlb_write_arbiter import csr_pkg::*, tlb_pkg::*; (
    input  tlb_write_req_t fill_req_i,
    input  tlb_write_req_t inv_req_i,
    output tlb_write_req_t wr_req_o,
    output logic           fill_gnt_o,
    output logic           inv_gnt_o
);

    logic fill_active;
    logic inv_active;

    // a request is live while its mask is non-zero
    assign fill_active = |fill_req_i.mask;
    assign inv_active  = |inv_req_i.mask;

    always_comb begin
        // invalidate always wins, fill waits
        inv_gnt_o  = inv_active;
        fill_gnt_o = fill_active && !inv_active;

        if (inv_active) begin
            wr_req_o = inv_req_i;
        end else if (fill_active) begin
            wr_req_o = fill_req_i;
        end else begin
            wr_req_o = '0;
        end
    end

endmodule

/* verilog/tlb_fill_unit.sv */
`timescale 1ns/1ps
`include "mmu_params.svh"

module tlb_fill_unit import csr_pkg::*, tlb_pkg::*; (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           tlbwr_i,
    input  logic           tlbfill_i,
    input  csr_t           csr_i,
    input  tlb_entry_t     entry_i,
    input  logic           gnt_i,
    output tlb_write_req_t req_o
);

    tlb_index_t  fill_cnt_q;
    tlb_index_t  wr_idx;
    tlb_onehot_t mask_q;
    tlb_entry_t  entry_q;
    logic        cmd;
    logic        pending;

    assign cmd     = tlbwr_i || tlbfill_i;
    assign pending = |mask_q;

    // tlbfill picks its victim from the counter, tlbwr from tlbidx
    assign wr_idx = tlbfill_i ? fill_cnt_q : csr_i.tlbidx[`MMU_TLBIDX_INDEX];

    // free-running victim pointer
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fill_cnt_q <= '0;
        end else begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mask_q <= '0;
        end else if (cmd) begin
            mask_q <= tlb_onehot_t'(1) << wr_idx;
        end else if (gnt_i) begin
            mask_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd) begin
            entry_q <= entry_i;
        end
    end

    assign req_o = '{mask: mask_q, entry: entry_q};

    a_no_cmd_while_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        cmd |-> !pending);

endmodule

/* verilog/tlb_inv_unit.sv */
`timescale 1ns/1ps
`include "mmu_params.svh"

module tlb_inv_unit import csr_pkg::*, tlb_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                invtlb_i,
    input  invtlb_op_t                          op_i,
    input  asid_t                               asid_i,
    input  vaddr_t                              va_i,
    input  tlb_entry_t [`MMU_TLB_ENTRY_NUM-1:0] entries_i,
    input  logic                                gnt_i,
    output tlb_write_req_t                      req_o
);

    logic        pend_q;
    invtlb_op_t  op_q;
    asid_t       asid_q;
    vaddr_t      va_q;
    tlb_onehot_t match;

    // an empty match finishes without touching the array
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else if (invtlb_i) begin
            pend_q <= 1'b1;
        end else if (gnt_i || match == '0) begin
            pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (invtlb_i) begin
            op_q   <= op_i;
            asid_q <= asid_i;
            va_q   <= va_i;
        end
    end

    // per-op selection rule
    always_comb begin
        tlb_key_t key;
        logic     asid_hit;
        logic     va_hit;
        for (int i = 0; i < `MMU_TLB_ENTRY_NUM; i++) begin
            key      = entries_i[i].key;
            asid_hit = key.asid == asid_q;
            va_hit   = vppn_match(va_q, key.huge_page, key.vppn);
            case (op_q)
                INV_ALL0, INV_ALL1: match[i] = key.e;
                INV_GLOBAL:         match[i] = key.e && key.g;
                INV_NONGLOBAL:      match[i] = key.e && !key.g;
                INV_NG_ASID:        match[i] = key.e && !key.g && asid_hit;
                INV_NG_ASID_VA:     match[i] = key.e && !key.g && asid_hit && va_hit;
                INV_G_ASID_VA:      match[i] = key.e && (key.g || asid_hit) && va_hit;
                default:            match[i] = 1'b0;
            endcase
        end
    end

    // cleared entries are written as all zero
    always_comb begin
        req_o = '0;
        if (pend_q) begin
            req_o.mask = match;
        end
    end

endmodule

/* verilog/mmu.sv */
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu import csr_pkg::*, tlb_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  vaddr_t                              va_i,
    input  mem_type_t                           mem_type_i,
    input  csr_t                                csr_i,
    input  tlb_entry_t [`MMU_TLB_ENTRY_NUM-1:0] entries_i,
    output trans_result_t                       trans_result_o,
    output ecode_t                              ecode_o
);

    asid_t         cur_asid;
    plv_t          cur_plv;
    logic          paging;
    logic          tlb_found;
    logic          tlb_huge;
    tlb_value_t    tlb_value;
    logic          dmw0_hit;
    logic          dmw1_hit;
    logic [31:0]   dmw_sel;
    trans_result_t result_d;
    logic          tlb_mode_d;
    logic          tlb_mode_q;
    tlb_value_t    tlb_value_q;
    mem_type_t     mem_type_q;
    plv_t          plv_q;

    function automatic logic dmw_match(input logic [31:0] dmw, input vaddr_t va,
                                       input plv_t plv);
        logic plv_ok;
        plv_ok = (plv == PLV_KERNEL && dmw[`MMU_DMW_PLV0])
              || (plv == PLV_USER && dmw[`MMU_DMW_PLV3]);
        return plv_ok && (dmw[`MMU_DMW_VSEG] == va[31:29]);
    endfunction

    assign cur_asid = csr_i.asid[`MMU_ASID_ASID];
    assign cur_plv  = csr_i.crmd[`MMU_CRMD_PLV];
    // mapped mode needs pg set and da clear
    assign paging   = csr_i.crmd[`MMU_CRMD_PG] && !csr_i.crmd[`MMU_CRMD_DA];

    // fully associative lookup
    always_comb begin
        tlb_found = 1'b0;
        tlb_huge  = 1'b0;
        tlb_value = '0;
        for (int i = 0; i < `MMU_TLB_ENTRY_NUM; i++) begin
            if (entries_i[i].key.e
                && (entries_i[i].key.g || entries_i[i].key.asid == cur_asid)
                && vppn_match(va_i, entries_i[i].key.huge_page, entries_i[i].key.vppn)) begin
                tlb_found = 1'b1;
                tlb_huge  = entries_i[i].key.huge_page;
                // odd/even page select moves with page size
                tlb_value = entries_i[i].key.huge_page ? entries_i[i].value[va_i[21]]
                                                       : entries_i[i].value[va_i[12]];
            end
        end
    end

    assign dmw0_hit = dmw_match(csr_i.dmw0, va_i, cur_plv);
    assign dmw1_hit = dmw_match(csr_i.dmw1, va_i, cur_plv);
    assign dmw_sel  = dmw0_hit ? csr_i.dmw0 : csr_i.dmw1;

    // dmw beats tlb, direct mode when paging is off
    always_comb begin
        result_d.pa    = va_i;
        result_d.mat   = (mem_type_i == MEM_FETCH) ? csr_i.crmd[`MMU_CRMD_DATF]
                                                   : csr_i.crmd[`MMU_CRMD_DATM];
        result_d.valid = 1'b1;
        tlb_mode_d     = 1'b0;
        if (paging) begin
            if (dmw0_hit || dmw1_hit) begin
                result_d.pa  = {dmw_sel[`MMU_DMW_PSEG], va_i[28:0]};
                result_d.mat = dmw_sel[`MMU_DMW_MAT];
            end else begin
                result_d.pa    = tlb_huge ? {tlb_value.ppn[19:10], va_i[21:0]}
                                          : {tlb_value.ppn, va_i[11:0]};
                result_d.mat   = tlb_value.mat;
                result_d.valid = tlb_found;
                tlb_mode_d     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trans_result_o <= '0;
            tlb_mode_q     <= 1'b0;
        end else if (flush_i) begin
            trans_result_o.valid <= 1'b0;
            tlb_mode_q           <= 1'b0;
        end else begin
            trans_result_o <= result_d;
            tlb_mode_q     <= tlb_mode_d;
        end
    end

    always_ff @(posedge clk) begin
        tlb_value_q <= tlb_value;
        mem_type_q  <= mem_type_i;
        plv_q       <= cur_plv;
    end

    // second stage raises exceptions only in tlb mode
    always_comb begin
        ecode_o = ECODE_NONE;
        if (tlb_mode_q) begin
            if (!trans_result_o.valid) begin
                ecode_o = ECODE_TLBR;
            end else if (!tlb_value_q.v) begin
                case (mem_type_q)
                    MEM_FETCH: ecode_o = ECODE_PIF;
                    MEM_STORE: ecode_o = ECODE_PIS;
                    default:   ecode_o = ECODE_PIL;
                endcase
            end else if (plv_q > tlb_value_q.plv) begin
                ecode_o = ECODE_PPI;
            end else if (mem_type_q == MEM_STORE && !tlb_value_q.d) begin
                ecode_o = ECODE_PME;
            end
        end
    end

endmodule

/* verilog/mmu_top.sv */
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_top import csr_pkg::*, tlb_pkg::*; (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          flush_i,
    input  csr_t          csr_i,
    input  vaddr_t        if_va_i,
    output trans_result_t if_result_o,
    output ecode_t        if_ecode_o,
    input  vaddr_t        dt_va_i,
    input  mem_type_t     dt_mem_type_i,
    output trans_result_t dt_result_o,
    output ecode_t        dt_ecode_o,
    input  logic          tlbwr_i,
    input  logic          tlbfill_i,
    input  tlb_entry_t    wr_entry_i,
    input  logic          invtlb_i,
    input  invtlb_op_t    inv_op_i,
    input  asid_t         inv_asid_i,
    input  vaddr_t        inv_va_i
);

    tlb_entry_t [`MMU_TLB_ENTRY_NUM-1:0] entries;
    tlb_write_req_t                      fill_req;
    tlb_write_req_t                      inv_req;
    tlb_write_req_t                      wr_req;
    logic                                fill_gnt;
    logic                                inv_gnt;

    tlb_array i_array (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_req_i  (wr_req),
        .entries_o (entries)
    );

    tlb_write_arbiter i_arbiter (
        .fill_req_i (fill_req),
        .inv_req_i  (inv_req),
        .wr_req_o   (wr_req),
        .fill_gnt_o (fill_gnt),
        .inv_gnt_o  (inv_gnt)
    );

    tlb_fill_unit i_fill (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .tlbwr_i   (tlbwr_i),
        .tlbfill_i (tlbfill_i),
        .csr_i     (csr_i),
        .entry_i   (wr_entry_i),
        .gnt_i     (fill_gnt),
        .req_o     (fill_req)
    );

    tlb_inv_unit i_inv (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .invtlb_i  (invtlb_i),
        .op_i      (inv_op_i),
        .asid_i    (inv_asid_i),
        .va_i      (inv_va_i),
        .entries_i (entries),
        .gnt_i     (inv_gnt),
        .req_o     (inv_req)
    );

    // fetch port only ever fetches
    mmu i_mmu_if (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .va_i           (if_va_i),
        .mem_type_i     (MEM_FETCH),
        .csr_i          (csr_i),
        .entries_i      (entries),
        .trans_result_o (if_result_o),
        .ecode_o        (if_ecode_o)
    );

    mmu i_mmu_dt (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .va_i           (dt_va_i),
        .mem_type_i     (dt_mem_type_i),
        .csr_i          (csr_i),
        .entries_i      (entries),
        .trans_result_o (dt_result_o),
        .ecode_o        (dt_ecode_o)
    );

endmodule

/* testbench/tb_mmu_top.sv */
`timescale 1ns/1ps

module tb_mmu_top import csr_pkg::*, tlb_pkg::*; ();

    // one parsed line of the case file
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] pa;
        logic [1:0]  mat;
        logic        valid;
        logic [5:0]  ecode;
    } case_t;

    logic          clk;
    logic          rst_n_i;
    logic          flush_i;
    csr_t          csr_i;
    vaddr_t        if_va_i;
    trans_result_t if_result_o;
    ecode_t        if_ecode_o;
    vaddr_t        dt_va_i;
    mem_type_t     dt_mem_type_i;
    trans_result_t dt_result_o;
    ecode_t        dt_ecode_o;
    logic          tlbwr_i;
    logic          tlbfill_i;
    tlb_entry_t    wr_entry_i;
    logic          invtlb_i;
    invtlb_op_t    inv_op_i;
    asid_t         inv_asid_i;
    vaddr_t        inv_va_i;

    string ops[$];
    case_t cases[$];
    int    errors;
    int    cycles;
    int    cycle_limit;

    mmu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // limit is armed once the case list length is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the case list did not complete", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_result(input string port, input trans_result_t res, input ecode_t ec,
                                input case_t c, input logic [11:0] off);
        check_field({port, "_result_o.valid"}, 32'(c.valid), 32'(res.valid));
        check_field({port, "_ecode_o"}, 32'(c.ecode), 32'(ec));
        // pa and mat only carry meaning on a valid translation
        if (c.valid) begin
            check_field({port, "_result_o.pa"}, c.pa | 32'(off), res.pa);
            check_field({port, "_result_o.mat"}, 32'(c.mat), 32'(res.mat));
        end
    endtask

    // requests drop once the array write has landed
    task automatic finish_maintenance();
        @(posedge clk);
        #2;
        tlbwr_i   = 1'b0;
        tlbfill_i = 1'b0;
        invtlb_i  = 1'b0;
        while ((|i_dut.fill_req.mask) || (|i_dut.inv_req.mask)) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic translate(input string op, input case_t c);
        logic [11:0] off;
        off = 12'($urandom);
        if (op == "if") begin
            if_va_i = c.a | 32'(off);
        end else begin
            dt_va_i       = c.a | 32'(off);
            dt_mem_type_i = mem_type_t'(c.b[1:0]);
            flush_i       = (op == "flush");
        end
        @(posedge clk);
        #1;
        if (op == "if") begin
            check_result("if", if_result_o, if_ecode_o, c, off);
        end else begin
            check_result("dt", dt_result_o, dt_ecode_o, c, off);
        end
        #1;
        flush_i = 1'b0;
    endtask

    task automatic run_case(input string op, input case_t c);
        case (op)
            "csr": begin
                csr_i.crmd = c.a;
                csr_i.asid = c.b;
                csr_i.dmw0 = c.c;
                csr_i.dmw1 = c.d;
            end
            "wr": begin
                csr_i.tlbidx = c.a;
                // odd page sits above the even page
                wr_entry_i   = {c.b, c.d[25:0], c.c[25:0]};
                tlbwr_i      = 1'b1;
                finish_maintenance();
            end
            "fill": begin
                wr_entry_i = {c.b, c.d[25:0], c.c[25:0]};
                tlbfill_i  = 1'b1;
                finish_maintenance();
            end
            "inv": begin
                inv_op_i   = invtlb_op_t'(c.a[2:0]);
                inv_asid_i = c.b[9:0];
                inv_va_i   = c.c;
                invtlb_i   = 1'b1;
                finish_maintenance();
            end
            "invfill": begin
                inv_op_i   = invtlb_op_t'(c.a[2:0]);
                inv_asid_i = '0;
                inv_va_i   = '0;
                wr_entry_i = {c.b, c.d[25:0], c.c[25:0]};
                invtlb_i   = 1'b1;
                tlbfill_i  = 1'b1;
                finish_maintenance();
            end
            "if", "dt", "flush": begin
                translate(op, c);
            end
            "rst": begin
                rst_n_i = 1'b0;
                @(posedge clk);
                #1;
                check_result("if", if_result_o, if_ecode_o, c, '0);
                check_result("dt", dt_result_o, dt_ecode_o, c, '0);
                #1;
                rst_n_i = 1'b1;
            end
            default: begin
                errors++;
                $display("unknown operation %s in the case file", op);
            end
        endcase
    endtask

    task automatic read_cases();
        int          fd;
        int          cnt;
        string       line;
        string       op;
        logic [31:0] a, b, cc, d, pa, mat, valid, ecode;
        fd = $fopen("testbench/mmu_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open testbench/mmu_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                                  op, a, b, cc, d, pa, mat, valid, ecode);
                    if (cnt == 9) begin
                        ops.push_back(op);
                        cases.push_back('{a, b, cc, d, pa, mat[1:0], valid[0], ecode[5:0]});
                    end else begin
                        errors++;
                        $display("malformed line in the case file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        errors        = 0;
        cycles        = 0;
        cycle_limit   = 0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        csr_i         = '0;
        if_va_i       = '0;
        dt_va_i       = '0;
        dt_mem_type_i = MEM_LOAD;
        tlbwr_i       = 1'b0;
        tlbfill_i     = 1'b0;
        wr_entry_i    = '0;
        invtlb_i      = 1'b0;
        inv_op_i      = INV_ALL0;
        inv_asid_i    = '0;
        inv_va_i      = '0;
        void'($urandom(32'h5d6c137e));
        read_cases();
        cycle_limit = 2 * cases.size() * 4 + 20;
        repeat (3) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        foreach (cases[i]) begin
            run_case(ops[i], cases[i]);
        end
        @(posedge clk);
        $display("%0d errors over %0d cases", errors, cases.size());
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* testbench/mmu_cases.txt */
# op a b c d exp_pa exp_mat exp_valid exp_ecode, all numbers hex
# csr a=crmd b=asid c=dmw0 d=dmw1 / wr a=index b=key c=even d=odd / fill as wr without index
# inv a=op b=asid c=va / invfill a=op b c d as fill / if a=va / dt, flush a=va b=mem / rst
csr     128      5        0        0        0        0 0 00
if      12345000 0        0        0        12345000 1 1 00
dt      9abcd000 1        0        0        9abcd000 2 1 00
wr      0        80280200 3410000  2820001  0        0 0 00
wr      1        e0000400 3430000  3340000  0        0 0 00
wr      2        80280300 50       2400060  0        0 0 00
wr      3        80380380 3400070  0        0        0 0 00
wr      4        c0040001 3c00099  0        0        0 0 00
csr     10       5        80000011 a2000001 0        0 0 00
dt      80002000 1        0        0        00002000 1 1 00
if      a0010000 0        0        0        20010000 0 1 00
dt      00400000 1        0        0        10000000 1 1 00
dt      00401000 1        0        0        20001000 2 1 00
if      00800000 0        0        0        30000000 1 1 00
dt      00a00000 1        0        0        40200000 0 1 00
dt      00700000 1        0        0        0        0 0 3f
dt      00600000 1        0        0        00050000 0 1 01
dt      00600000 2        0        0        00050000 0 1 02
if      00600000 0        0        0        00050000 0 1 03
dt      00601000 2        0        0        00060000 1 1 04
dt      00601000 1        0        0        00060000 1 1 00
# user level
csr     13       5        80000011 a2000001 0        0 0 00
dt      00400000 1        0        0        10000000 1 1 07
dt      00601000 2        0        0        00060000 1 1 07
if      00a00000 0        0        0        40200000 0 1 00
csr     10       7        80000011 a2000001 0        0 0 00
dt      00700000 1        0        0        00070000 1 1 00
dt      00400000 1        0        0        0        0 0 3f
# invalidate ops 4, 2 and 5
inv     4        7        0        0        0        0 0 00
dt      00700000 1        0        0        0        0 0 3f
inv     2        0        0        0        0        0 0 00
csr     10       5        80000011 a2000001 0        0 0 00
if      00800000 0        0        0        0        0 0 3f
dt      00400000 1        0        0        10000000 1 1 00
inv     5        5        00601000 0        0        0 0 00
dt      00601000 1        0        0        0        0 0 3f
dt      00401000 1        0        0        20001000 2 1 00
fill    0        c0000600 3400abc  0        0        0 0 00
dt      00c00000 1        0        0        00abc000 1 1 00
invfill 0        c0000700 3400def  0        0        0 0 00
dt      00e00000 1        0        0        00def000 1 1 00
dt      00c00000 1        0        0        0        0 0 3f
flush   00e00000 1        0        0        0        0 0 00
rst     0        0        0        0        0        0 0 00
dt      00e00000 1        0        0        0        0 0 3f

/* all.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/tlb_pkg.sv
verilog/tlb_array.sv
verilog/tlb_write_arbiter.sv
verilog/tlb_fill_unit.sv
verilog/tlb_inv_unit.sv
verilog/mmu.sv
verilog/mmu_top.sv
testbench/tb_mmu_top.sv

/* Bender.yml */
package:
  name: mmu

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/csr_pkg.sv
      - verilog/tlb_pkg.sv
      - verilog/tlb_array.sv
      - verilog/tlb_write_arbiter.sv
      - verilog/tlb_fill_unit.sv
      - verilog/tlb_inv_unit.sv
      - verilog/mmu.sv
      - verilog/mmu_top.sv
  - target: test
    files:
      - testbench/tb_mmu_top.sv
